// File: hdl/psx_pad_pkg.sv
package psx_pad_pkg;

    // Fixed response bytes ahead of the button word
    localparam logic [7:0] PSX_IDLE_BYTE = 8'hff;
    localparam logic [7:0] PSX_ID_LO     = 8'h41;   // Digital pad ID, low byte
    localparam logic [7:0] PSX_ID_HI     = 8'h5a;

    localparam int PSX_FRAME_BYTES = 5;    // Idle, two ID bytes, two button bytes
    localparam int PSX_CLK_HALF    = 4;    // clk cycles per psx_clk half period
    localparam int PSX_ACK_CYCLES  = 2;    // Width of the ack low pulse

    // Report FIFO geometry
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;

    // Poller FSM encoding
    localparam logic [1:0] POLL_IDLE     = 2'd0;
    localparam logic [1:0] POLL_CLOCK    = 2'd1;
    localparam logic [1:0] POLL_ACK_WAIT = 2'd2;
    localparam logic [1:0] POLL_FINISH   = 2'd3;

    // D-pad direction codes, clockwise from up
    localparam logic [3:0] DPAD_NONE       = 4'd0;
    localparam logic [3:0] DPAD_UP         = 4'd1;
    localparam logic [3:0] DPAD_UP_RIGHT   = 4'd2;
    localparam logic [3:0] DPAD_RIGHT      = 4'd3;
    localparam logic [3:0] DPAD_DOWN_RIGHT = 4'd4;
    localparam logic [3:0] DPAD_DOWN       = 4'd5;
    localparam logic [3:0] DPAD_DOWN_LEFT  = 4'd6;
    localparam logic [3:0] DPAD_LEFT       = 4'd7;
    localparam logic [3:0] DPAD_UP_LEFT    = 4'd8;

    // Button word, active low, MSB first
    typedef struct packed {
        logic btn_square;     // Byte 4, bit 7
        logic btn_cross;
        logic btn_circle;
        logic btn_triangle;
        logic btn_r1;
        logic btn_l1;
        logic btn_r2;
        logic btn_l2;         // Byte 4, bit 0
        logic btn_left;       // Byte 3, bit 7
        logic btn_down;
        logic btn_right;
        logic btn_up;
        logic btn_start;
        logic btn_unused2;
        logic btn_unused1;
        logic btn_select;     // Byte 3, bit 0
    } psx_buttons_t;

    // Same word seen as wire bytes: bytes[0] is byte 3, bytes[1] is byte 4
    typedef union packed {
        logic [1:0][7:0] bytes;
        psx_buttons_t    named;
    } psx_buttons_u;

endpackage

// File: hdl/psx_pad_emulator.sv
module psx_pad_emulator import psx_pad_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         psx_clk,     // Host serial clock, idles high
    input  logic         att,         // Host select, active low
    input  psx_buttons_u buttons,     // Active-low buttons to report
    output logic         data,        // Serial response, LSB first
    output logic         ack          // Byte acknowledge, active low
);

    logic [39:0] chain;               // All five bytes, byte 0 in the low bits
    logic [5:0]  bit_cnt;             // Bits shifted out this frame
    logic [5:0]  bit_cnt_next;
    logic        psx_clk_q;           // Last psx_clk for edge detect
    logic        psx_clk_fall;
    logic        data_bit;            // Bit currently on the line
    logic [1:0]  ack_cnt;             // Cycles ack has been low
    logic        ack_due;

    assign psx_clk_fall = psx_clk_q & ~psx_clk;
    assign bit_cnt_next = bit_cnt + 6'd1;

    // Byte boundary after bytes 0 to 3, none after the last byte
    assign ack_due = (bit_cnt_next[2:0] == 3'd0) &&
                     (bit_cnt_next <= 6'(8 * (PSX_FRAME_BYTES - 1)));

    assign data = data_bit | att;     // Line pulled high while deselected

    always_ff @(posedge clk) begin
        if (reset) begin
            psx_clk_q <= 1'b1;
        end else begin
            psx_clk_q <= psx_clk;
        end
    end

    // Bit pointer and line driver
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt  <= '0;
            data_bit <= 1'b1;
        end else if (att) begin
            bit_cnt  <= '0;           // Rearm for the next frame
            data_bit <= 1'b1;
        end else if (psx_clk_fall) begin
            bit_cnt  <= bit_cnt_next;
            data_bit <= chain[0];     // Next bit goes out one cycle after the fall
        end
    end

    // Preload while deselected, buttons captured here
    always_ff @(posedge clk) begin
        if (att) begin
            chain <= {buttons.bytes[1], buttons.bytes[0], PSX_ID_HI, PSX_ID_LO,
                      PSX_IDLE_BYTE};
        end else if (psx_clk_fall) begin
            chain <= {1'b1, chain[39:1]};   // Ones fill from the top
        end
    end

    // Ack pulse of PSX_ACK_CYCLES after each of the first four bytes
    always_ff @(posedge clk) begin
        if (reset) begin
            ack     <= 1'b1;
            ack_cnt <= '0;
        end else if (att) begin
            ack     <= 1'b1;
            ack_cnt <= '0;
        end else if (psx_clk_fall && ack_due) begin
            ack     <= 1'b0;
            ack_cnt <= '0;
        end else if (!ack) begin
            if (ack_cnt == 2'(PSX_ACK_CYCLES - 1)) begin
                ack <= 1'b1;          // Pulse complete
            end else begin
                ack_cnt <= ack_cnt + 2'd1;
            end
        end
    end

endmodule

// File: hdl/psx_poller.sv
module psx_poller import psx_pad_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         poll,        // Start a frame when idle
    input  logic         full,        // Report FIFO full
    input  logic         ack,         // Pad acknowledge, active low
    input  logic         data,        // Serial data from the pad
    output logic         psx_clk,
    output logic         att,
    output logic         wr_en,       // One-cycle report write
    output psx_buttons_u wr_data
);

    logic [1:0] state;
    logic [2:0] div_cnt;              // Half-period divider
    logic [2:0] bit_cnt;              // Bit within the current byte
    logic [2:0] byte_cnt;             // Byte within the frame
    logic [7:0] rx_byte;
    logic [7:0] rx_next;
    logic       ack_seen;             // Ack went low during this byte
    logic       half_done;
    logic       sample;               // Rising edge of psx_clk this cycle
    logic       byte_done;

    assign half_done = (div_cnt == 3'(PSX_CLK_HALF - 1));
    assign sample    = (state == POLL_CLOCK) && half_done && !psx_clk;
    assign byte_done = sample && (bit_cnt == 3'd7);
    assign rx_next   = {data, rx_byte[7:1]};    // LSB arrives first
    assign wr_en     = (state == POLL_FINISH);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= POLL_IDLE;
            psx_clk  <= 1'b1;
            att      <= 1'b1;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            ack_seen <= 1'b0;
        end else begin
            if (!ack) begin
                ack_seen <= 1'b1;     // Pulse may end before the last rise
            end
            case (state)
                POLL_IDLE: begin
                    psx_clk <= 1'b1;
                    att     <= 1'b1;
                    // Poll dropped while the FIFO is full
                    if (poll && !full) begin
                        att      <= 1'b0;
                        state    <= POLL_CLOCK;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                        ack_seen <= 1'b0;
                    end
                end
                POLL_CLOCK: begin
                    div_cnt <= div_cnt + 3'd1;
                    if (half_done) begin
                        div_cnt <= '0;
                        psx_clk <= ~psx_clk;
                        if (sample) begin
                            bit_cnt <= bit_cnt + 3'd1;   // Wraps to 0 after bit 7
                        end
                    end
                    if (byte_done) begin
                        if (byte_cnt == 3'(PSX_FRAME_BYTES - 1)) begin
                            state <= POLL_FINISH;     // No ack after the last byte
                        end else begin
                            state <= POLL_ACK_WAIT;
                        end
                    end
                end
                POLL_ACK_WAIT: begin
                    // psx_clk parked high until ack has gone low and back
                    if (ack_seen && ack) begin
                        state    <= POLL_CLOCK;
                        byte_cnt <= byte_cnt + 3'd1;
                        div_cnt  <= '0;
                        ack_seen <= 1'b0;
                    end
                end
                POLL_FINISH: begin
                    att   <= 1'b1;    // End of frame, report written this cycle
                    state <= POLL_IDLE;
                end
                default: state <= POLL_IDLE;
            endcase
        end
    end

    // Byte assembly, only the two button bytes are kept
    always_ff @(posedge clk) begin
        if (sample) begin
            rx_byte <= rx_next;
        end
        if (byte_done && byte_cnt == 3'(PSX_FRAME_BYTES - 2)) begin
            wr_data.bytes[0] <= rx_next;
        end
        if (byte_done && byte_cnt == 3'(PSX_FRAME_BYTES - 1)) begin
            wr_data.bytes[1] <= rx_next;
        end
    end

endmodule

// File: hdl/psx_report_fifo.sv
module psx_report_fifo import psx_pad_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         wr_en,
    input  psx_buttons_u wr_data,
    input  logic         rd_en,
    output psx_buttons_u rd_data,     // Head entry, valid while not empty
    output logic         full,
    output logic         empty
);

    psx_buttons_u       mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;        // One extra bit to hold FIFO_DEPTH
    logic               do_wr;
    logic               do_rd;

    assign full    = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_wr   = wr_en && !full;  // Guard against overflow
    assign do_rd   = rd_en && !empty;
    assign rd_data = mem[rd_ptr];

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps naturally at depth 4
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// File: hdl/psx_button_decoder.sv
module psx_button_decoder import psx_pad_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         read,        // External read strobe
    input  logic         empty,
    input  psx_buttons_u rd_data,     // Head report, active low
    output logic         rd_en,       // Pop strobe to the FIFO
    output logic [15:0]  pressed,     // Active-high button flags
    output logic [3:0]   dpad_dir,
    output logic         changed,     // Differs from the previous report
    output logic         report_valid
);

    psx_buttons_u pressed_next;       // Head report flipped to active high
    logic [3:0]   dpad_bits;          // Up, right, down, left
    logic [3:0]   dir_next;

    assign rd_en        = read & ~empty;  // Read on empty is ignored
    assign pressed_next = ~rd_data;
    assign dpad_bits    = {pressed_next.named.btn_up, pressed_next.named.btn_right,
                           pressed_next.named.btn_down, pressed_next.named.btn_left};

    // Single direction or adjacent pair, anything else counts as none
    always_comb begin
        case (dpad_bits)
            4'b1000: dir_next = DPAD_UP;
            4'b1100: dir_next = DPAD_UP_RIGHT;
            4'b0100: dir_next = DPAD_RIGHT;
            4'b0110: dir_next = DPAD_DOWN_RIGHT;
            4'b0010: dir_next = DPAD_DOWN;
            4'b0011: dir_next = DPAD_DOWN_LEFT;
            4'b0001: dir_next = DPAD_LEFT;
            4'b1001: dir_next = DPAD_UP_LEFT;
            default: dir_next = DPAD_NONE;   // Opposing or three-way presses
        endcase
    end

    // Outputs hold until the next successful read
    always_ff @(posedge clk) begin
        if (reset) begin
            pressed      <= '0;
            dpad_dir     <= DPAD_NONE;
            changed      <= 1'b0;
            report_valid <= 1'b0;
        end else if (rd_en) begin
            pressed      <= pressed_next;
            dpad_dir     <= dir_next;
            // First report after reset always counts as a change
            changed      <= !report_valid || (pressed_next != pressed);
            report_valid <= 1'b1;
        end
    end

endmodule

// File: hdl/psx_pad_subsystem.sv
module psx_pad_subsystem import psx_pad_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         poll,        // Start one frame
    input  logic         read,        // Pop one report
    input  psx_buttons_u buttons,     // Pad button state, active low
    output logic [15:0]  pressed,
    output logic [3:0]   dpad_dir,
    output logic         changed,
    output logic         report_valid
);

    // Serial link
    logic psx_clk;
    logic att;
    logic data;
    logic ack;

    // Report path
    logic         wr_en;
    psx_buttons_u wr_data;
    logic         rd_en;
    psx_buttons_u rd_data;
    logic         full;
    logic         empty;

    psx_poller psx_poller_inst (
        .clk     (clk),
        .reset   (reset),
        .poll    (poll),
        .full    (full),
        .ack     (ack),
        .data    (data),
        .psx_clk (psx_clk),
        .att     (att),
        .wr_en   (wr_en),
        .wr_data (wr_data)
    );

    psx_pad_emulator psx_pad_emulator_inst (
        .clk     (clk),
        .reset   (reset),
        .psx_clk (psx_clk),
        .att     (att),
        .buttons (buttons),
        .data    (data),
        .ack     (ack)
    );

    psx_report_fifo psx_report_fifo_inst (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .full    (full),
        .empty   (empty)
    );

    psx_button_decoder psx_button_decoder_inst (
        .clk          (clk),
        .reset        (reset),
        .read         (read),
        .empty        (empty),
        .rd_data      (rd_data),
        .rd_en        (rd_en),
        .pressed      (pressed),
        .dpad_dir     (dpad_dir),
        .changed      (changed),
        .report_valid (report_valid)
    );

endmodule

// File: tb/psx_pad_assertions.sv
module psx_pad_assertions import psx_pad_pkg::*; (
    input logic clk,
    input logic reset,
    input logic att,
    input logic data_bit,             // Line driver ahead of the att gate
    input logic ack
);

    logic [3:0] low_len;              // Consecutive cycles with ack low

    always_ff @(posedge clk) begin
        if (reset || ack) begin
            low_len <= '0;
        end else begin
            low_len <= low_len + 4'd1;
        end
    end

    ack_width: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> low_len == 4'(PSX_ACK_CYCLES))
        else $error("ack pulse was %0d cycles long", low_len);

    // Driver released high one cycle into deselect
    data_idle: assert property (@(posedge clk) disable iff (reset)
        att && $past(att) |-> data_bit)
        else $error("data not released high while att is high");

    ack_idle: assert property (@(posedge clk) disable iff (reset) att |-> ack)
        else $error("ack low while att is high");

endmodule

bind psx_pad_emulator psx_pad_assertions psx_pad_assertions_inst (
    .clk      (clk),
    .reset    (reset),
    .att      (att),
    .data_bit (data_bit),
    .ack      (ack)
);

// File: tb/psx_pad_checker.sv
module psx_pad_checker import psx_pad_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         poll,
    input logic         read,
    input psx_buttons_u buttons,
    input logic [15:0]  pressed,
    input logic [3:0]   dpad_dir,
    input logic         changed,
    input logic         report_valid
);

    psx_buttons_u expected_q[$];      // Words accepted by the FIFO model
    psx_buttons_u head;
    logic [15:0]  exp_pressed = '0;
    logic [3:0]   exp_dir     = '0;
    logic         exp_changed = 1'b0;
    logic         exp_valid   = 1'b0;
    logic         pending     = 1'b0; // Read seen last falling edge
    int           error_count  = 0;
    int           check_count  = 0;
    int           test_errors  = 0;
    int           tests_run    = 0;
    int           tests_failed = 0;

    // Expected {changed, dpad_dir, pressed} for one report
    function automatic logic [20:0] ref_decode(input psx_buttons_u w,
                                               input logic [15:0] prev, input logic first);
        logic [15:0] flags;
        logic        up;
        logic        right;
        logic        down;
        logic        left;
        int          n;
        logic [3:0]  dir;
        flags = ~w;
        up    = ~w.named.btn_up;
        right = ~w.named.btn_right;
        down  = ~w.named.btn_down;
        left  = ~w.named.btn_left;
        n     = int'(up) + int'(right) + int'(down) + int'(left);
        dir   = DPAD_NONE;
        if (n == 1) begin
            dir = up ? DPAD_UP : right ? DPAD_RIGHT : down ? DPAD_DOWN : DPAD_LEFT;
        end else if (n == 2) begin            // Only neighbours make a diagonal
            if (up && right)        dir = DPAD_UP_RIGHT;
            else if (right && down) dir = DPAD_DOWN_RIGHT;
            else if (down && left)  dir = DPAD_DOWN_LEFT;
            else if (left && up)    dir = DPAD_UP_LEFT;
        end
        return {first || (flags != prev), dir, flags};
    endfunction

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            test_errors++;
            $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
        end
        test_errors = 0;
    endtask

    // Falling edge sampling, inputs and outputs both stable here
    always @(negedge clk) begin
        if (reset) begin
            expected_q.delete();
            exp_pressed = '0;
            exp_dir     = DPAD_NONE;
            exp_changed = 1'b0;
            exp_valid   = 1'b0;
            pending     = 1'b0;
        end else begin
            if (pending) begin                // Outputs one cycle after the read
                compare("pressed", pressed, exp_pressed);
                compare("dpad_dir", 16'(dpad_dir), 16'(exp_dir));
                compare("changed", 16'(changed), 16'(exp_changed));
                compare("report_valid", 16'(report_valid), 16'(exp_valid));
                pending = 1'b0;
            end
            if (poll && expected_q.size() < FIFO_DEPTH) begin
                expected_q.push_back(buttons);   // Dropped when full
            end
            if (read) begin
                if (expected_q.size() > 0) begin
                    head = expected_q.pop_front();
                    {exp_changed, exp_dir, exp_pressed} =
                        ref_decode(head, exp_pressed, !exp_valid);
                    exp_valid = 1'b1;
                end
                pending = 1'b1;               // Empty read expects no change
            end
        end
    end

endmodule

// File: tb/psx_pad_tb.sv
module psx_pad_tb import psx_pad_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int FRAME_CYCLES    = 40 * 2 * PSX_CLK_HALF;  // 40 bits at one psx_clk period each
    localparam int SETTLE_CYCLES   = 2 * FRAME_CYCLES;       // Generous poll-to-report bound
    localparam int NUM_FRAMES      = 29;                     // Polls over all five tests
    localparam int OVERHEAD_CYCLES = 600;                    // Reset, ack waits and reads
    localparam int WATCHDOG_TIME   =
        (NUM_FRAMES * FRAME_CYCLES * 3 + OVERHEAD_CYCLES) * CLK_PERIOD;

    logic         clk;
    logic         reset;
    logic         poll;
    logic         read;
    psx_buttons_u buttons;            // Active low, as on the wire
    logic [15:0]  pressed;
    logic [3:0]   dpad_dir;
    logic         changed;
    logic         report_valid;
    logic [15:0]  word;               // Random stimulus word
    int           i;

    psx_pad_subsystem psx_pad_subsystem_inst (
        .clk          (clk),
        .reset        (reset),
        .poll         (poll),
        .read         (read),
        .buttons      (buttons),
        .pressed      (pressed),
        .dpad_dir     (dpad_dir),
        .changed      (changed),
        .report_valid (report_valid)
    );

    psx_pad_checker psx_pad_checker_inst (
        .clk          (clk),
        .reset        (reset),
        .poll         (poll),
        .read         (read),
        .buttons      (buttons),
        .pressed      (pressed),
        .dpad_dir     (dpad_dir),
        .changed      (changed),
        .report_valid (report_valid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Present a button word and strobe poll for one cycle
    task automatic poll_pad(input logic [15:0] pad_word);
        @(posedge clk);
        buttons <= pad_word;
        poll    <= 1'b1;
        @(posedge clk);
        poll    <= 1'b0;
        repeat (SETTLE_CYCLES) @(posedge clk);   // Frame latency varies with ack
    endtask

    // One-cycle read strobe, then room for the checker
    task automatic read_report();
        @(posedge clk);
        read <= 1'b1;
        @(posedge clk);
        read <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // Run limit
    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hc553_fbe4));
        reset   = 1'b1;
        poll    = 1'b0;
        read    = 1'b0;
        buttons = 16'hffff;           // Nothing pressed
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Test 1, read with nothing polled
        repeat (10) @(posedge clk);
        read_report();
        psx_pad_checker_inst.report_test("read after reset");

        // Test 2, left only
        poll_pad(16'hff7f);
        read_report();
        psx_pad_checker_inst.report_test("single poll");

        // Test 3, repeat then a new word
        poll_pad(16'hbfef);           // Up and cross
        poll_pad(16'hbfef);
        read_report();
        read_report();
        poll_pad(16'hffdf);           // Right only
        read_report();
        psx_pad_checker_inst.report_test("changed flag");

        // Test 4, fifth poll hits a full FIFO
        poll_pad(16'hfeff);
        poll_pad(16'hfdff);
        poll_pad(16'hfbff);
        poll_pad(16'hf7ff);
        poll_pad(16'hefff);
        repeat (5) read_report();
        psx_pad_checker_inst.report_test("full FIFO");

        // Test 5, random words with forced d-pad corner cases
        for (i = 0; i < 20; i++) begin
            word = 16'($urandom());
            if (i % 5 == 0) begin
                word[7:4] = 4'b1010;  // Up and down together
            end else if (i % 5 == 1) begin
                word[7:4] = 4'b1000;  // Up, right and down
            end
            poll_pad(word);
            read_report();
        end
        psx_pad_checker_inst.report_test("random words");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 psx_pad_checker_inst.tests_run, psx_pad_checker_inst.tests_failed,
                 psx_pad_checker_inst.check_count, psx_pad_checker_inst.error_count);
        if (psx_pad_checker_inst.error_count == 0 && psx_pad_checker_inst.tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
hdl/psx_pad_pkg.sv
hdl/psx_pad_emulator.sv
hdl/psx_poller.sv
hdl/psx_report_fifo.sv
hdl/psx_button_decoder.sv
hdl/psx_pad_subsystem.sv
tb/psx_pad_assertions.sv
tb/psx_pad_checker.sv
tb/psx_pad_tb.sv

// File: Makefile
TOP = psx_pad_tb

sim:
	rm -rf obj_dir
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
